/* Makefile */
VERILATOR  ?= verilator
FILELIST   := src.f
TB_TOP     := efpga_subsys_tb
RTL_TOP    := efpga_subsys_top
LINT_FLAGS := --lint-only -sv --timing
SIM_FLAGS  := --binary -sv --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Testbench failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/efpga_subsys_tb.sv */
// ============================
// self-checking testbench for the eFPGA glue subsystem
// random stimulus, reference models and concurrent assertions
// ============================
`timescale 1ns/1ps

module efpga_subsys_tb;

  localparam int unsigned NP          = efpga_subsys_pkg::N_TCDM_PORTS;
  localparam int unsigned SEQ_EN_CYC  = 2400;  // sequencer enabled
  localparam int unsigned TOTAL_CYC   = 3000;  // rest runs in bypass
  localparam int unsigned CLK_PERIOD  = 8;
  localparam int unsigned WDOG_NS     = (TOTAL_CYC + 3 + 50) * CLK_PERIOD;

  logic asic_clk_i;
  logic rst_n;

  efpga_subsys_pkg::data_t        control_i, control_o;
  efpga_subsys_pkg::event_vec_t   events_i, event_o;
  logic                           enable_events_i;
  logic                           enable_apb_i, host_req_i, host_wen_i;
  efpga_subsys_pkg::fabric_addr_t host_addr_i, fab_addr_o;
  efpga_subsys_pkg::data_t        host_wdata_i, host_rdata_o, fab_wdata_o, fab_rdata_i;
  efpga_subsys_pkg::be_t          host_be_i, fab_be_o;
  logic                           host_gnt_o, host_rvalid_o;
  logic                           fab_req_o, fab_wen_o, fab_gnt_i, fab_rvalid_i;
  efpga_subsys_pkg::port_vec_t    enable_tcdm_i;

  logic                           tcdm_fab_req_i    [NP];
  logic                           tcdm_fab_wen_i    [NP];
  efpga_subsys_pkg::fabric_addr_t tcdm_fab_addr_i   [NP];
  efpga_subsys_pkg::be_t          tcdm_fab_be_i     [NP];
  efpga_subsys_pkg::data_t        tcdm_fab_wdata_i  [NP];
  logic                           tcdm_fab_gnt_o    [NP];
  logic                           tcdm_fab_rvalid_o [NP];
  efpga_subsys_pkg::data_t        tcdm_fab_rdata_o  [NP];
  logic                           tcdm_soc_req_o    [NP];
  logic                           tcdm_soc_wen_o    [NP];
  efpga_subsys_pkg::soc_addr_t    tcdm_soc_addr_o   [NP];
  efpga_subsys_pkg::be_t          tcdm_soc_be_o     [NP];
  efpga_subsys_pkg::data_t        tcdm_soc_wdata_o  [NP];
  logic                           tcdm_soc_gnt_i    [NP];
  logic                           tcdm_soc_rvalid_i [NP];
  efpga_subsys_pkg::data_t        tcdm_soc_rdata_i  [NP];

  efpga_subsys_top dut_i (.*);

  logic [31:0] lcg_state = 32'hd7ad_7b07;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  initial begin
    asic_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) asic_clk_i = ~asic_clk_i;
  end

  initial begin
    #(WDOG_NS);
    abort_run("timeout, the test sequence did not complete in time");
  end

  // control filter model, counts edges with an unchanged word
  efpga_subsys_pkg::data_t ctrl_last_q, ctrl_pend_val_q, exp_ctrl;
  int unsigned             ctrl_cnt_q;
  int unsigned             ctrl_cnt_nx;
  logic                    ctrl_pend_q;

  assign ctrl_cnt_nx = (control_i == ctrl_last_q) ? ctrl_cnt_q + 1 : 1;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_last_q     <= '0;
      ctrl_cnt_q      <= 2;  // zero word counts as already seen
      ctrl_pend_q     <= 1'b0;
      ctrl_pend_val_q <= '0;
      exp_ctrl        <= '0;
    end else begin
      ctrl_last_q     <= control_i;
      ctrl_cnt_q      <= (ctrl_cnt_nx > 3) ? 3 : ctrl_cnt_nx;
      ctrl_pend_q     <= (ctrl_cnt_nx >= 3);
      ctrl_pend_val_q <= control_i;
      if (ctrl_pend_q) exp_ctrl <= ctrl_pend_val_q;
    end
  end

  // event model and sequencer request run length
  efpga_subsys_pkg::event_vec_t ev_lvl_q, exp_ev, ev_lvl;
  int unsigned                  run_q;

  assign ev_lvl = enable_events_i ? events_i : '0;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ev_lvl_q <= '0;
      exp_ev   <= '0;
      run_q    <= 0;
    end else begin
      ev_lvl_q <= ev_lvl;
      exp_ev   <= ev_lvl & ~ev_lvl_q;
      if (!host_req_i) run_q <= 0;
      else if (run_q < efpga_subsys_pkg::GNT_DELAY) run_q <= run_q + 1;
    end
  end

  a_ctrl: assert property (@(posedge asic_clk_i) disable iff (!rst_n) control_o == exp_ctrl)
    else abort_run($sformatf("** Error control_o = 0x%h, expected 0x%h",
                             $sampled(control_o), $sampled(exp_ctrl)));
  a_evt: assert property (@(posedge asic_clk_i) disable iff (!rst_n) event_o == exp_ev)
    else abort_run($sformatf("** Error event_o = 0x%h, expected 0x%h",
                             $sampled(event_o), $sampled(exp_ev)));
  a_fab_req: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      fab_req_o == (enable_apb_i && host_req_i && run_q == 0))
    else abort_run($sformatf("** Error fab_req_o = 0x%h, expected 0x%h", $sampled(fab_req_o),
                             $sampled(enable_apb_i && host_req_i && run_q == 0)));
  a_gnt: assert property (@(posedge asic_clk_i) disable iff (!rst_n) host_gnt_o == (enable_apb_i
      ? (run_q >= efpga_subsys_pkg::GNT_DELAY && fab_gnt_i) : host_req_i))
    else abort_run($sformatf("** Error host_gnt_o = 0x%h, run 0x%h, fab_gnt_i 0x%h",
                             $sampled(host_gnt_o), $sampled(run_q), $sampled(fab_gnt_i)));
  a_rvalid: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      host_rvalid_o == (enable_apb_i ? fab_rvalid_i : 1'b1))
    else abort_run($sformatf("** Error host_rvalid_o = 0x%h, fab_rvalid_i 0x%h",
                             $sampled(host_rvalid_o), $sampled(fab_rvalid_i)));
  a_payload: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      {fab_wen_o, fab_addr_o, fab_wdata_o, fab_be_o, host_rdata_o}
      == {host_wen_i, host_addr_i, host_wdata_i, host_be_i, fab_rdata_i})
    else abort_run($sformatf("** Error fab_addr_o = 0x%h (host 0x%h), host_rdata_o = 0x%h (0x%h)",
                             $sampled(fab_addr_o), $sampled(host_addr_i),
                             $sampled(host_rdata_o), $sampled(fab_rdata_i)));

  // per-port read tracking and checks
  for (genvar p = 0; p < NP; p++) begin : g_port_chk
    logic rd_q;  // last accepted request was a read

    always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) rd_q <= 1'b1;
      else if (enable_tcdm_i[p] && tcdm_fab_req_i[p]) rd_q <= tcdm_fab_wen_i[p];
    end

    a_addr: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
        tcdm_soc_addr_o[p][31:20] == efpga_subsys_pkg::SOC_ADDR_BASE &&
        (!enable_tcdm_i[p] || tcdm_soc_addr_o[p][19:0] == tcdm_fab_addr_i[p]))
      else abort_run($sformatf("** Error tcdm_soc_addr_o[%0d] = 0x%h, fabric addr 0x%h", p,
                               $sampled(tcdm_soc_addr_o[p]), $sampled(tcdm_fab_addr_i[p])));
    a_req: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
        tcdm_soc_req_o[p] == (enable_tcdm_i[p] && tcdm_fab_req_i[p]) &&
        tcdm_fab_gnt_o[p] == (enable_tcdm_i[p] && tcdm_soc_gnt_i[p]))
      else abort_run($sformatf("** Error tcdm_soc_req_o[%0d] = 0x%h, tcdm_fab_gnt_o = 0x%h, en 0x%h",
                               p, $sampled(tcdm_soc_req_o[p]), $sampled(tcdm_fab_gnt_o[p]),
                               $sampled(enable_tcdm_i[p])));
    // idle port shows a read with no bytes and no data
    a_soc_pay: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
        {tcdm_soc_wen_o[p], tcdm_soc_be_o[p], tcdm_soc_wdata_o[p]} == (enable_tcdm_i[p]
        ? {tcdm_fab_wen_i[p], tcdm_fab_be_i[p], tcdm_fab_wdata_i[p]} : {1'b1, 4'h0, 32'h0}))
      else abort_run($sformatf("** Error tcdm_soc_wdata_o[%0d] = 0x%h, wen 0x%h, be 0x%h",
                               p, $sampled(tcdm_soc_wdata_o[p]), $sampled(tcdm_soc_wen_o[p]),
                               $sampled(tcdm_soc_be_o[p])));
    a_rv: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
        tcdm_fab_rvalid_o[p] == (tcdm_soc_rvalid_i[p] && rd_q) &&
        tcdm_fab_rdata_o[p] == tcdm_soc_rdata_i[p])
      else abort_run($sformatf("** Error tcdm_fab_rvalid_o[%0d] = 0x%h, expected 0x%h", p,
                               $sampled(tcdm_fab_rvalid_o[p]),
                               $sampled(tcdm_soc_rvalid_i[p] && rd_q)));
  end

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    int unsigned ctrl_hold;

    rst_n = 1'b0;
    control_i = '0;
    events_i = '0;
    enable_events_i = 1'b0;
    enable_apb_i = 1'b1;
    {host_req_i, host_wen_i, host_addr_i, host_wdata_i, host_be_i} = '0;
    {fab_gnt_i, fab_rvalid_i, fab_rdata_i} = '0;
    enable_tcdm_i = '0;
    for (int p = 0; p < NP; p++) begin
      tcdm_fab_req_i[p] = 1'b0;
      tcdm_fab_wen_i[p] = 1'b1;
      tcdm_fab_addr_i[p] = '0;
      tcdm_fab_be_i[p] = '0;
      tcdm_fab_wdata_i[p] = '0;
      tcdm_soc_gnt_i[p] = 1'b0;
      tcdm_soc_rvalid_i[p] = 1'b0;
      tcdm_soc_rdata_i[p] = '0;
    end
    ctrl_hold = 0;
    repeat (3) @(posedge asic_clk_i);
    rst_n <= 1'b1;

    for (int unsigned cyc = 0; cyc < TOTAL_CYC; cyc++) begin
      @(posedge asic_clk_i);
      r = lcg_next();
      r2 = lcg_next();
      // short holds of 1..2 edges, long holds of 4..7
      if (ctrl_hold == 0) begin
        control_i <= r2;
        ctrl_hold = r[0] ? 32'(r[1]) : 32'(r[3:2]) + 3;
      end else begin
        ctrl_hold--;
      end
      if (r[7:4] == 4'h0) events_i <= r2[31:16];
      if (r[12:8] == 5'h0) enable_events_i <= ~enable_events_i;
      enable_apb_i <= (cyc < SEQ_EN_CYC);
      if (!host_req_i || host_gnt_o) begin  // idle or handshake done
        host_req_i   <= (r[14:13] != 2'b00);
        host_wen_i   <= r[15];
        host_be_i    <= r[19:16];
        host_addr_i  <= r2[19:0];
        host_wdata_i <= lcg_next();
      end
      fab_gnt_i    <= (r[21:20] != 2'b00);
      fab_rvalid_i <= fab_req_o & fab_wen_o;
      fab_rdata_i  <= lcg_next();
      for (int p = 0; p < NP; p++) begin
        r = lcg_next();
        if (r[4:0] == 5'h0) enable_tcdm_i[p] <= ~enable_tcdm_i[p];
        tcdm_fab_req_i[p]    <= r[5];
        tcdm_fab_wen_i[p]    <= r[6];
        tcdm_fab_be_i[p]     <= r[10:7];
        tcdm_fab_addr_i[p]   <= lcg_next();
        tcdm_fab_wdata_i[p]  <= lcg_next();
        tcdm_soc_gnt_i[p]    <= r[11] | r[12];
        tcdm_soc_rvalid_i[p] <= r[13];
        tcdm_soc_rdata_i[p]  <= lcg_next();
      end
    end

    @(posedge asic_clk_i);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* hw/control_word_filter.sv */
// ============================
// passes the host control word to the fabric once it has been
// stable for three consecutive clock edges
// ============================
`timescale 1ns/1ps

module control_word_filter (
  input  logic                     asic_clk_i,
  input  logic                     rst_n,
  input  efpga_subsys_pkg::data_t  control_i,
  output efpga_subsys_pkg::data_t  control_o
);

  efpga_subsys_pkg::data_t ctrl_d1_q;  // sample of previous edge
  efpga_subsys_pkg::data_t ctrl_d2_q;  // sample two edges back
  logic                    stable_q;

  // three samples in a row must agree before the word counts
  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_d1_q <= '0;
      ctrl_d2_q <= '0;
      stable_q  <= 1'b0;
    end else begin
      ctrl_d1_q <= control_i;
      ctrl_d2_q <= ctrl_d1_q;
      stable_q  <= (ctrl_d2_q == control_i) && (ctrl_d1_q == control_i);
    end
  end

  // d1 still holds the last of the three matching samples here
  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      control_o <= '0;
    end else if (stable_q) begin
      control_o <= ctrl_d1_q;
    end
  end

endmodule

/* hw/efpga_subsys_pkg.sv */
// ============================
// shared constants and vector types of the eFPGA glue subsystem
// referenced by scoped name from every RTL file
// ============================
package efpga_subsys_pkg;

  // memory ports from the fabric into the SoC map
  localparam int unsigned N_TCDM_PORTS = 4;

  // event lines from the fabric
  localparam int unsigned N_EVENTS = 16;

  // word address as seen by the fabric
  localparam int unsigned FABRIC_ADDR_W = 20;

  // upper address bits that place the fabric window in the SoC map
  localparam logic [11:0] SOC_ADDR_BASE = 12'h1C0;

  // depth of the type-1 request history, sets the host grant delay
  localparam int unsigned GNT_DELAY = 5;

  // data word on both buses
  typedef logic [31:0] data_t;

  // byte enables for one data word
  typedef logic [3:0] be_t;

  // fabric side address
  typedef logic [FABRIC_ADDR_W-1:0] fabric_addr_t;

  // full SoC address, base on top of fabric address
  typedef logic [31:0] soc_addr_t;

  // one bit per fabric event
  typedef logic [N_EVENTS-1:0] event_vec_t;

  // one bit per memory port
  typedef logic [N_TCDM_PORTS-1:0] port_vec_t;

endpackage

/* hw/efpga_subsys_top.sv */
// ============================
// glue between the eFPGA fabric and the SoC interconnect
// fabric and SoC connect to the ports, one clock asic_clk_i
// ============================
`timescale 1ns/1ps

module efpga_subsys_top (
  input  logic                           asic_clk_i,
  input  logic                           rst_n,

  // control word and events
  input  efpga_subsys_pkg::data_t        control_i,
  output efpga_subsys_pkg::data_t        control_o,
  input  efpga_subsys_pkg::event_vec_t   events_i,
  input  logic                           enable_events_i,
  output efpga_subsys_pkg::event_vec_t   event_o,

  // type-1 access
  input  logic                           enable_apb_i,
  input  logic                           host_req_i,
  input  logic                           host_wen_i,
  input  efpga_subsys_pkg::fabric_addr_t host_addr_i,
  input  efpga_subsys_pkg::data_t        host_wdata_i,
  input  efpga_subsys_pkg::be_t          host_be_i,
  output logic                           host_gnt_o,
  output logic                           host_rvalid_o,
  output efpga_subsys_pkg::data_t        host_rdata_o,
  output logic                           fab_req_o,
  output logic                           fab_wen_o,
  output efpga_subsys_pkg::fabric_addr_t fab_addr_o,
  output efpga_subsys_pkg::data_t        fab_wdata_o,
  output efpga_subsys_pkg::be_t          fab_be_o,
  input  logic                           fab_gnt_i,
  input  logic                           fab_rvalid_i,
  input  efpga_subsys_pkg::data_t        fab_rdata_i,

  // memory ports, fabric side
  input  efpga_subsys_pkg::port_vec_t    enable_tcdm_i,
  input  logic                           tcdm_fab_req_i   [efpga_subsys_pkg::N_TCDM_PORTS],
  input  logic                           tcdm_fab_wen_i   [efpga_subsys_pkg::N_TCDM_PORTS],
  input  efpga_subsys_pkg::fabric_addr_t tcdm_fab_addr_i  [efpga_subsys_pkg::N_TCDM_PORTS],
  input  efpga_subsys_pkg::be_t          tcdm_fab_be_i    [efpga_subsys_pkg::N_TCDM_PORTS],
  input  efpga_subsys_pkg::data_t        tcdm_fab_wdata_i [efpga_subsys_pkg::N_TCDM_PORTS],
  output logic                           tcdm_fab_gnt_o   [efpga_subsys_pkg::N_TCDM_PORTS],
  output logic                           tcdm_fab_rvalid_o[efpga_subsys_pkg::N_TCDM_PORTS],
  output efpga_subsys_pkg::data_t        tcdm_fab_rdata_o [efpga_subsys_pkg::N_TCDM_PORTS],

  // memory ports, SoC side
  output logic                           tcdm_soc_req_o   [efpga_subsys_pkg::N_TCDM_PORTS],
  output logic                           tcdm_soc_wen_o   [efpga_subsys_pkg::N_TCDM_PORTS],
  output efpga_subsys_pkg::soc_addr_t    tcdm_soc_addr_o  [efpga_subsys_pkg::N_TCDM_PORTS],
  output efpga_subsys_pkg::be_t          tcdm_soc_be_o    [efpga_subsys_pkg::N_TCDM_PORTS],
  output efpga_subsys_pkg::data_t        tcdm_soc_wdata_o [efpga_subsys_pkg::N_TCDM_PORTS],
  input  logic                           tcdm_soc_gnt_i   [efpga_subsys_pkg::N_TCDM_PORTS],
  input  logic                           tcdm_soc_rvalid_i[efpga_subsys_pkg::N_TCDM_PORTS],
  input  efpga_subsys_pkg::data_t        tcdm_soc_rdata_i [efpga_subsys_pkg::N_TCDM_PORTS]
);

  control_word_filter ctrl_filter_i (
    .asic_clk_i (asic_clk_i),
    .rst_n      (rst_n),
    .control_i  (control_i),
    .control_o  (control_o)
  );

  event_bridge event_bridge_i (
    .asic_clk_i      (asic_clk_i),
    .rst_n           (rst_n),
    .events_i        (events_i),
    .enable_events_i (enable_events_i),
    .event_o         (event_o)
  );

  lint_access_ctrl lint_ctrl_i (
    .asic_clk_i    (asic_clk_i),
    .rst_n         (rst_n),
    .enable_apb_i  (enable_apb_i),
    .host_req_i    (host_req_i),
    .host_wen_i    (host_wen_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_be_i     (host_be_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .fab_req_o     (fab_req_o),
    .fab_wen_o     (fab_wen_o),
    .fab_addr_o    (fab_addr_o),
    .fab_wdata_o   (fab_wdata_o),
    .fab_be_o      (fab_be_o),
    .fab_gnt_i     (fab_gnt_i),
    .fab_rvalid_i  (fab_rvalid_i),
    .fab_rdata_i   (fab_rdata_i)
  );

  // each port uses its own enable bit
  for (genvar g = 0; g < efpga_subsys_pkg::N_TCDM_PORTS; g++) begin : g_tcdm
    tcdm_port tcdm_port_i (
      .asic_clk_i   (asic_clk_i),
      .rst_n        (rst_n),
      .enable_i     (enable_tcdm_i[g]),
      .fab_req_i    (tcdm_fab_req_i[g]),
      .fab_wen_i    (tcdm_fab_wen_i[g]),
      .fab_addr_i   (tcdm_fab_addr_i[g]),
      .fab_be_i     (tcdm_fab_be_i[g]),
      .fab_wdata_i  (tcdm_fab_wdata_i[g]),
      .fab_gnt_o    (tcdm_fab_gnt_o[g]),
      .fab_rvalid_o (tcdm_fab_rvalid_o[g]),
      .fab_rdata_o  (tcdm_fab_rdata_o[g]),
      .soc_req_o    (tcdm_soc_req_o[g]),
      .soc_wen_o    (tcdm_soc_wen_o[g]),
      .soc_addr_o   (tcdm_soc_addr_o[g]),
      .soc_be_o     (tcdm_soc_be_o[g]),
      .soc_wdata_o  (tcdm_soc_wdata_o[g]),
      .soc_gnt_i    (tcdm_soc_gnt_i[g]),
      .soc_rvalid_i (tcdm_soc_rvalid_i[g]),
      .soc_rdata_i  (tcdm_soc_rdata_i[g])
    );
  end

endmodule

/* hw/event_bridge.sv */
// ============================
// gates fabric event levels with the event enable and turns each
// rising edge into a one-cycle event pulse towards the SoC
// ============================
`timescale 1ns/1ps

module event_bridge (
  input  logic                         asic_clk_i,
  input  logic                         rst_n,
  input  efpga_subsys_pkg::event_vec_t events_i,
  input  logic                         enable_events_i,
  output efpga_subsys_pkg::event_vec_t event_o
);

  efpga_subsys_pkg::event_vec_t event_gate;
  efpga_subsys_pkg::event_vec_t event_gate_q;  // gated level at last edge
  efpga_subsys_pkg::event_vec_t event_rise;

  assign event_gate = events_i & {efpga_subsys_pkg::N_EVENTS{enable_events_i}};

  // held level gives one pulse only
  assign event_rise = event_gate & ~event_gate_q;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      event_gate_q <= '0;
    end else begin
      event_gate_q <= event_gate;
    end
  end

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      event_o <= '0;
    end else begin
      event_o <= event_rise;  // registered pulse
    end
  end

endmodule

/* hw/lint_access_ctrl.sv */
// ============================
// type-1 access sequencer from the SoC into the fabric, one fabric
// request per held host request and a delayed host grant
// ============================
`timescale 1ns/1ps

module lint_access_ctrl (
  input  logic                           asic_clk_i,
  input  logic                           rst_n,
  input  logic                           enable_apb_i,

  // host side
  input  logic                           host_req_i,
  input  logic                           host_wen_i,
  input  efpga_subsys_pkg::fabric_addr_t host_addr_i,
  input  efpga_subsys_pkg::data_t        host_wdata_i,
  input  efpga_subsys_pkg::be_t          host_be_i,
  output logic                           host_gnt_o,
  output logic                           host_rvalid_o,
  output efpga_subsys_pkg::data_t        host_rdata_o,

  // fabric side
  output logic                           fab_req_o,
  output logic                           fab_wen_o,
  output efpga_subsys_pkg::fabric_addr_t fab_addr_o,
  output efpga_subsys_pkg::data_t        fab_wdata_o,
  output efpga_subsys_pkg::be_t          fab_be_o,
  input  logic                           fab_gnt_i,
  input  logic                           fab_rvalid_i,
  input  efpga_subsys_pkg::data_t        fab_rdata_i
);

  localparam int unsigned HIST_W = efpga_subsys_pkg::GNT_DELAY;

  logic [HIST_W-1:0] req_hist_q;  // one bit per edge with req held

  // history restarts as soon as the host drops its request
  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      req_hist_q <= '0;
    end else if (!host_req_i) begin
      req_hist_q <= '0;
    end else begin
      req_hist_q <= {req_hist_q[HIST_W-2:0], host_req_i};
    end
  end

  // masked re-request, only the head of a held request reaches the fabric
  assign fab_req_o = enable_apb_i ? host_req_i & ~req_hist_q[0] : 1'b0;

  // grant waits for the full history and the fabric grant
  assign host_gnt_o = enable_apb_i ? req_hist_q[HIST_W-1] & fab_gnt_i : host_req_i;

  assign host_rvalid_o = enable_apb_i ? fab_rvalid_i : 1'b1;  // always valid in bypass
  assign host_rdata_o  = fab_rdata_i;

  // payload goes straight through
  assign fab_wen_o   = host_wen_i;
  assign fab_addr_o  = host_addr_i;
  assign fab_wdata_o = host_wdata_i;
  assign fab_be_o    = host_be_i;

endmodule

/* hw/tcdm_port.sv */
// ============================
// one fabric-to-SoC memory port, adds the SoC address base, gates
// the port with its enable and qualifies read responses
// ============================
`timescale 1ns/1ps

module tcdm_port (
  input  logic                           asic_clk_i,
  input  logic                           rst_n,
  input  logic                           enable_i,

  // fabric side
  input  logic                           fab_req_i,
  input  logic                           fab_wen_i,
  input  efpga_subsys_pkg::fabric_addr_t fab_addr_i,
  input  efpga_subsys_pkg::be_t          fab_be_i,
  input  efpga_subsys_pkg::data_t        fab_wdata_i,
  output logic                           fab_gnt_o,
  output logic                           fab_rvalid_o,
  output efpga_subsys_pkg::data_t        fab_rdata_o,

  // SoC side
  output logic                           soc_req_o,
  output logic                           soc_wen_o,
  output efpga_subsys_pkg::soc_addr_t    soc_addr_o,
  output efpga_subsys_pkg::be_t          soc_be_o,
  output efpga_subsys_pkg::data_t        soc_wdata_o,
  input  logic                           soc_gnt_i,
  input  logic                           soc_rvalid_i,
  input  efpga_subsys_pkg::data_t        soc_rdata_i
);

  logic wen_q;  // wen of last request, 1 = read

  // request side, nothing leaves a disabled port
  assign soc_req_o   = enable_i & fab_req_i;
  assign soc_wen_o   = enable_i ? fab_wen_i : 1'b1;
  assign soc_addr_o  = {efpga_subsys_pkg::SOC_ADDR_BASE, enable_i ? fab_addr_i : '0};
  assign soc_be_o    = enable_i ? fab_be_i : '0;
  assign soc_wdata_o = enable_i ? fab_wdata_i : '0;

  assign fab_gnt_o = enable_i & soc_gnt_i;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wen_q <= 1'b1;  // default read
    end else if (soc_req_o) begin
      wen_q <= soc_wen_o;
    end
  end

  // write responses are not passed on as read data
  assign fab_rvalid_o = soc_rvalid_i & wen_q;
  assign fab_rdata_o  = soc_rdata_i;

endmodule

/* src.f */
hw/efpga_subsys_pkg.sv
hw/control_word_filter.sv
hw/event_bridge.sv
hw/lint_access_ctrl.sv
hw/tcdm_port.sv
hw/efpga_subsys_top.sv
bench/efpga_subsys_tb.sv
